//--- sources.f
+incdir+.
atom_map_pkg.sv
atom_timing_pkg.sv
atom_clock_reset.sv
atom_bus_decode.sv
atom_pia.sv
atom_vid_ram.sv
atom_glue.sv
atom_glue_tb.sv

//--- atom_glue_tb_ref.svh
`ifndef atom_glue_tb_ref_svh
`define atom_glue_tb_ref_svh

// ==================================================
// Expected values from the memory map rules
// ==================================================

// Bus region of an address, exact matches before ranges
function automatic bus_region_t region_of(input logic [addr_w-1:0] a);
   if (a == 16'hbfff)
      return region_rom_latch;
   if (a >= 16'hb000 && a <= 16'hb00f)
      return region_pia;
   if (a >= 16'hb400 && a <= 16'hb40f)
      return region_blank;
   if (a >= 16'h8000 && a <= 16'h97ff)
      return region_vid;
   if ((a >= 16'ha000 && a <= 16'hafff) || a >= 16'hc000)
      return region_rom;
   return region_ram;
endfunction

// Paged window at A000, flat map elsewhere
function automatic logic [ram_addr_w-1:0] sram_addr_of(input logic [addr_w-1:0] a,
                                                        input logic [7:0] latch);
   if (a >= 16'ha000 && a <= 16'hafff)
      return {rom_page_prefix, latch[2:0], a[11:0]};
   return {2'b00, a};
endfunction

// SRAM write on an enable, never into ROM space
function automatic logic ram_we_expected(input logic clken, input logic r,
                                         input logic [addr_w-1:0] a);
   return clken && !r && (region_of(a) != region_rom);
endfunction

// 8255 read back, port C high nibble from the pins and the tone
function automatic logic [7:0] pia_read_value(input pia_port_t port, input logic [7:0] pa,
                                              input logic [3:0] pc, input logic [7:0] pb,
                                              input logic fs, input logic rept,
                                              input logic cin, input logic tone);
   case (port)
      pia_port_a: return pa;
      pia_port_b: return pb;
      pia_port_c: return {fs, rept, cin, tone, pc};
      default:    return 8'h00;
   endcase
endfunction

// Tone level after n enables since reset
function automatic logic tone_after(input int unsigned n);
   return ((n / cas_div_len) % 2) == 1;
endfunction

// PC0 enables, PC1 gates the tone in
function automatic logic cas_out_value(input logic [3:0] pc, input logic tone);
   return pc[0] && (!tone || !pc[1]);
endfunction

`endif

//--- atom_glue_tb.sv
`timescale 1ns/10ps
`default_nettype none

module atom_glue_tb import atom_map_pkg::*, atom_timing_pkg::*;
;

   localparam int clk_period   = 40;
   localparam int reset_cycles = 16;
   // One settling frame and three counted frames per turbo speed
   localparam int turbo_frames = 4;
   // Generous bound on bus enables for the whole run
   localparam int enable_budget = 4000;
   localparam int watchdog_clocks =
      2 * (reset_cycles + 4 * turbo_frames * div_frame + enable_budget * div_frame / 8);

   logic                  clk25;
   logic                  reset;
   turbo_t                turbo;
   logic [addr_w-1:0]     address;
   logic [7:0]            wdata;
   logic                  rnw;
   logic [7:0]            ext_rdata;
   logic [7:0]            kbd_pb;
   logic                  rept_n;
   logic                  cas_in;
   logic                  fs_n;
   logic [vid_addr_w-1:0] vid_addr;
   logic                  cpu_clken;
   logic [7:0]            rdata;
   logic [ram_addr_w-1:0] ram_addr;
   logic                  ram_we;
   logic                  lock;
   logic [3:0]            kbd_row;
   logic                  an_g;
   logic [2:0]            gm;
   logic                  css;
   logic                  cas_out;
   logic                  sound;
   logic [7:0]            vid_data;

   // Stimulus side models
   integer      seed = 32'hde80;
   int unsigned clken_seen = 0;
   int          fail_count = 0;
   logic [7:0]  ext_now;
   logic [7:0]  pa_model;
   logic [3:0]  pc_model;
   logic [7:0]  vid_model [0:(2**vid_addr_w)-1];
   logic [vid_addr_w-1:0] vid_offs [0:31];
   // Latch copy kept by the compare process
   logic [7:0]  latch_model = 8'h00;

   `include "atom_glue_tb_ref.svh"

   atom_glue atom_glue_inst (
      .clk25     (clk25),
      .reset     (reset),
      .turbo     (turbo),
      .address   (address),
      .wdata     (wdata),
      .rnw       (rnw),
      .ext_rdata (ext_rdata),
      .kbd_pb    (kbd_pb),
      .rept_n    (rept_n),
      .cas_in    (cas_in),
      .fs_n      (fs_n),
      .vid_addr  (vid_addr),
      .cpu_clken (cpu_clken),
      .rdata     (rdata),
      .ram_addr  (ram_addr),
      .ram_we    (ram_we),
      .lock      (lock),
      .kbd_row   (kbd_row),
      .an_g      (an_g),
      .gm        (gm),
      .css       (css),
      .cas_out   (cas_out),
      .sound     (sound),
      .vid_data  (vid_data)
   );

   initial
   begin
      clk25 = 1'b0;
      forever #(clk_period / 2) clk25 = ~clk25;
   end

   // ==================================================
   // Checks
   // ==================================================

   task automatic abort_run();
      $display("Test failed");
      $fatal(1, "run stopped at the first error");
   endtask

   task automatic check_byte(input string what, input logic [7:0] got, input logic [7:0] exp);
      if (got !== exp)
      begin
         fail_count++;
         $display("mismatch at %0t ns: %s is %h, expected %h", $time, what, got, exp);
         abort_run();
      end
   endtask

   task automatic check_addr(input string what, input logic [ram_addr_w-1:0] got,
                             input logic [ram_addr_w-1:0] exp);
      if (got !== exp)
      begin
         fail_count++;
         $display("mismatch at %0t ns: %s is %h, expected %h", $time, what, got, exp);
         abort_run();
      end
   endtask

   task automatic check_bit(input string what, input logic got, input logic exp);
      if (got !== exp)
      begin
         fail_count++;
         $display("mismatch at %0t ns: %s is %b, expected %b", $time, what, got, exp);
         abort_run();
      end
   endtask

   // SRAM address and write strobe on every edge
   always @(posedge clk25)
   begin
      if (!reset)
      begin
         check_addr("ram_addr", ram_addr, sram_addr_of(address, latch_model));
         check_bit("ram_we", ram_we, ram_we_expected(cpu_clken, rnw, address));
         if (cpu_clken && !rnw && address == 16'hbfff)
            latch_model = wdata;
      end
   end

   initial
   begin
      #(watchdog_clocks * clk_period);
      fail_count++;
      $display("timeout: the run did not finish within %0d clocks", watchdog_clocks);
      abort_run();
   end

   // ==================================================
   // Bus helpers
   // ==================================================

   function automatic logic [7:0] rand_byte();
      logic [31:0] r;
      r = $random(seed);
      return r[7:0];
   endfunction

   // One clock, counting every enable since reset release
   task automatic tick();
      @(posedge clk25);
      if (cpu_clken)
         clken_seen++;
   endtask

   task automatic wait_clken();
      tick();
      while (!cpu_clken)
         tick();
   endtask

   // Expected read data at the enable that ends the cycle
   function automatic logic [7:0] read_value_for(input logic [addr_w-1:0] a);
      case (region_of(a))
         region_vid:       return vid_model[a[vid_addr_w-1:0]];
         region_pia:       return pia_read_value(pia_port_t'(a[1:0]), pa_model, pc_model,
                                                 kbd_pb, fs_n, rept_n, cas_in,
                                                 tone_after(clken_seen - 1));
         region_blank:     return 8'h00;
         region_rom_latch: return latch_model;
         default:          return ext_now;
      endcase
   endfunction

   // Held from one enable to the next
   task automatic drive_cycle(input logic [addr_w-1:0] a, input logic [7:0] d, input logic r);
      ext_now = rand_byte();
      address   <= a;
      wdata     <= d;
      rnw       <= r;
      ext_rdata <= ext_now;
      wait_clken();
   endtask

   task automatic write_cycle(input logic [addr_w-1:0] a, input logic [7:0] d);
      drive_cycle(a, d, 1'b0);
   endtask

   task automatic read_check(input string what, input logic [addr_w-1:0] a,
                             output logic [7:0] got);
      drive_cycle(a, rand_byte(), 1'b1);
      got = rdata;
      check_byte(what, got, read_value_for(a));
   endtask

   // ==================================================
   // Stimulus
   // ==================================================

   initial
   begin
      logic [7:0]            rd;
      logic [7:0]            v;
      logic [7:0]            pulses;
      logic [31:0]           r32;
      logic [addr_w-1:0]     a;
      logic [vid_addr_w-1:0] off;
      int unsigned           eff;
      int                    flips;
      logic                  last_tone;
      logic                  lock_model;

      reset     = 1'b1;
      turbo     = turbo_1mhz;
      address   = '0;
      wdata     = 8'h00;
      rnw       = 1'b1;
      ext_rdata = 8'h00;
      kbd_pb    = 8'hff;
      rept_n    = 1'b0;
      cas_in    = 1'b1;
      fs_n      = 1'b1;
      vid_addr  = '0;
      pa_model  = 8'h00;
      pc_model  = 4'h0;
      repeat (reset_cycles) @(posedge clk25);
      reset <= 1'b0;

      // Enables per 25-clock frame at each speed
      for (int t = 0; t < 4; t++)
      begin
         turbo <= turbo_t'(t);
         repeat (div_frame) tick();
         repeat (turbo_frames - 1)
         begin
            pulses = 8'h00;
            repeat (div_frame)
            begin
               tick();
               if (cpu_clken)
                  pulses++;
            end
            check_byte($sformatf("enables per frame, turbo %0d", t), pulses, 8'(1 << t));
         end
      end
      wait_clken();

      // Power-up hold keeps PIA, latch and lock clear
      read_check("port A in power-up", 16'hb000, rd);
      read_check("ROM latch in power-up", 16'hbfff, rd);
      write_cycle(lock_addr, 8'hff);
      read_check("RAM read", 16'h0100, rd);
      check_bit("lock in power-up", lock, 1'b0);
      while (kbd_row != 4'ha)
      begin
         if (clken_seen > 2000)
         begin
            fail_count++;
            $display("port A stayed cleared past 2000 enables");
            abort_run();
         end
         write_cycle(16'hb000, 8'h5a);
      end
      eff = clken_seen - 1;
      check_bit($sformatf("power-up release at enable %0d", eff),
                eff >= 1023 && eff <= 1025, 1'b1);
      pa_model = 8'h5a;

      // Port A outputs and read back
      repeat (8)
      begin
         v = rand_byte();
         write_cycle(16'hb000, v);
         pa_model = v;
         read_check("port A", 16'hb000, rd);
         check_byte("kbd_row", {4'h0, kbd_row}, {4'h0, v[3:0]});
         check_bit("an_g", an_g, v[4]);
         check_byte("gm", {5'h00, gm}, {5'h00, v[7:5]});
      end
      // Port C low nibble
      repeat (8)
      begin
         v = rand_byte();
         write_cycle(16'hb002, v);
         pc_model = v[3:0];
         // Port C high nibble pins
         r32 = $random(seed);
         fs_n   <= r32[0];
         rept_n <= r32[1];
         cas_in <= r32[2];
         read_check("port C", 16'hb002, rd);
         check_bit("css", css, v[3]);
         check_bit("sound", sound, v[2]);
      end
      // Bit set and reset, mode words ignored
      repeat (16)
      begin
         v = rand_byte();
         write_cycle(16'hb003, v);
         if (!v[7])
            pc_model[v[2:1]] = v[0];
         read_check("port C after control write", 16'hb002, rd);
      end
      repeat (4)
      begin
         kbd_pb <= rand_byte();
         read_check("port B", 16'hb001, rd);
      end

      // ROM latch, paging and write masking
      write_cycle(16'hbfff, rand_byte());
      read_check("ROM latch", 16'hbfff, rd);
      read_check("paged ROM", 16'ha123, rd);
      write_cycle(16'ha456, rand_byte());
      write_cycle(16'hc000, rand_byte());
      write_cycle(16'h1234, rand_byte());
      read_check("blank area", 16'hb404, rd);
      repeat (64)
      begin
         do
         begin
            r32 = $random(seed);
            a = r32[15:0];
         end
         while (region_of(a) == region_vid || region_of(a) == region_pia || a == lock_addr);
         r32 = $random(seed);
         if (r32[0])
            read_check("random read", a, rd);
         else
            write_cycle(a, rand_byte());
      end

      // Video RAM through the bus
      for (int i = 0; i < 32; i++)
      begin
         do
         begin
            r32 = $random(seed);
            off = r32[vid_addr_w-1:0];
         end
         while (off >= 13'h1800);
         vid_offs[i] = off;
         v = rand_byte();
         write_cycle(16'h8000 + off, v);
         vid_model[off] = v;
      end
      for (int i = 0; i < 32; i++)
         read_check("video RAM", 16'h8000 + vid_offs[i], rd);
      // Display port, one clock of latency
      for (int i = 0; i < 32; i++)
      begin
         vid_addr <= vid_offs[i];
         tick();
         tick();
         check_byte("vid_data", vid_data, vid_model[vid_offs[i]]);
      end
      wait_clken();

      // Lock flag snoop
      lock_model = 1'b0;
      repeat (8)
      begin
         v = rand_byte();
         write_cycle(lock_addr, v);
         check_bit("lock", lock, lock_model);
         lock_model = v[lock_bit];
      end
      read_check("RAM read", 16'h0200, rd);
      check_bit("lock", lock, lock_model);

      // Cassette output over every port C setting
      for (int p = 0; p < 16; p++)
      begin
         write_cycle(16'hb002, 8'(p));
         pc_model = p[3:0];
         read_check("port C", 16'hb002, rd);
         check_bit("cas_out", cas_out, cas_out_value(pc_model, tone_after(clken_seen - 1)));
      end
      // Tone period seen through port C bit 4
      write_cycle(16'hb002, 8'h03);
      pc_model = 4'h3;
      read_check("port C", 16'hb002, rd);
      last_tone = rd[4];
      flips = 0;
      repeat (450)
      begin
         read_check("port C tone", 16'hb002, rd);
         check_bit("cas_out", cas_out, cas_out_value(pc_model, tone_after(clken_seen - 1)));
         if (rd[4] != last_tone)
            flips++;
         last_tone = rd[4];
      end
      check_bit("tone toggled twice", flips >= 2, 1'b1);

      if (fail_count == 0)
      begin
         $display("Test passed");
         $finish;
      end
      else
         abort_run();
   end

endmodule

`default_nettype wire

//--- atom_glue.sv
`timescale 1ns/10ps
`default_nettype none

module atom_glue import atom_map_pkg::*, atom_timing_pkg::*;
(
   input  wire logic                  clk25,
   input  wire logic                  reset,
   input  wire turbo_t                turbo,
   input  wire logic [addr_w-1:0]     address,
   input  wire logic [7:0]            wdata,
   input  wire logic                  rnw,
   input  wire logic [7:0]            ext_rdata,
   input  wire logic [7:0]            kbd_pb,
   input  wire logic                  rept_n,
   input  wire logic                  cas_in,
   input  wire logic                  fs_n,
   input  wire logic [vid_addr_w-1:0] vid_addr,
   output logic                       cpu_clken,
   output logic [7:0]                 rdata,
   output logic [ram_addr_w-1:0]      ram_addr,
   output logic                       ram_we,
   output logic                       lock,
   output logic [3:0]                 kbd_row,
   output logic                       an_g,
   output logic [2:0]                 gm,
   output logic                       css,
   output logic                       cas_out,
   output logic                       sound,
   output logic [7:0]                 vid_data
);

   logic        sys_reset;
   bus_region_t region;
   logic [7:0]  pia_rdata;
   logic [7:0]  vid_rdata;
   // Video RAM write strobe
   logic        vid_we;
   // PIA chip select
   logic        pia_sel;

   assign vid_we  = (region == region_vid) && !rnw && cpu_clken;
   assign pia_sel = (region == region_pia);

   // ==================================================
   // Clocks and resets
   // ==================================================

   atom_clock_reset atom_clock_reset_inst (
      .clk25     (clk25),
      .reset     (reset),
      .turbo     (turbo),
      .cpu_clken (cpu_clken),
      .sys_reset (sys_reset)
   );

   // ==================================================
   // Bus decode
   // ==================================================

   atom_bus_decode atom_bus_decode_inst (
      .clk25     (clk25),
      .reset     (reset),
      .sys_reset (sys_reset),
      .cpu_clken (cpu_clken),
      .address   (address),
      .wdata     (wdata),
      .rnw       (rnw),
      .pia_rdata (pia_rdata),
      .vid_rdata (vid_rdata),
      .ext_rdata (ext_rdata),
      .region    (region),
      .ram_addr  (ram_addr),
      .ram_we    (ram_we),
      .rdata     (rdata),
      .lock      (lock)
   );

   // ==================================================
   // Peripherals
   // ==================================================

   // Register select from address bits 1..0
   atom_pia atom_pia_inst (
      .clk25     (clk25),
      .reset     (reset),
      .sys_reset (sys_reset),
      .cpu_clken (cpu_clken),
      .pia_sel   (pia_sel),
      .port_sel  (pia_port_t'(address[1:0])),
      .wdata     (wdata),
      .rnw       (rnw),
      .kbd_pb    (kbd_pb),
      .rept_n    (rept_n),
      .cas_in    (cas_in),
      .fs_n      (fs_n),
      .pia_rdata (pia_rdata),
      .kbd_row   (kbd_row),
      .an_g      (an_g),
      .gm        (gm),
      .css       (css),
      .cas_out   (cas_out),
      .sound     (sound)
   );

   atom_vid_ram atom_vid_ram_inst (
      .clk25     (clk25),
      .we        (vid_we),
      .cpu_addr  (address[vid_addr_w-1:0]),
      .wdata     (wdata),
      .cpu_rdata (vid_rdata),
      .vid_addr  (vid_addr),
      .vid_data  (vid_data)
   );

endmodule

`default_nettype wire

//--- atom_vid_ram.sv
`timescale 1ns/10ps
`default_nettype none

module atom_vid_ram import atom_map_pkg::*;
(
   input  wire logic                  clk25,
   input  wire logic                  we,
   input  wire logic [vid_addr_w-1:0] cpu_addr,
   input  wire logic [7:0]            wdata,
   output logic [7:0]                 cpu_rdata,
   input  wire logic [vid_addr_w-1:0] vid_addr,
   output logic [7:0]                 vid_data
);

   // ==================================================
   // Storage
   // ==================================================

   // 8 KB, display reads the low 6 KB
   logic [7:0] mem [0:(2**vid_addr_w)-1];

   // ==================================================
   // CPU port
   // ==================================================

   // Read and write share the address
   // Same-cycle read returns old data
   always_ff @(posedge clk25)
   begin
      if (we)
         mem[cpu_addr] <= wdata;
      cpu_rdata <= mem[cpu_addr];
   end

   // ==================================================
   // Display port
   // ==================================================

   // Read only, one clock latency
   always_ff @(posedge clk25)
   begin
      vid_data <= mem[vid_addr];
   end

endmodule

`default_nettype wire

//--- atom_pia.sv
`timescale 1ns/10ps
`default_nettype none

module atom_pia import atom_map_pkg::*, atom_timing_pkg::*;
(
   input  wire logic      clk25,
   input  wire logic      reset,
   input  wire logic      sys_reset,
   input  wire logic      cpu_clken,
   input  wire logic      pia_sel,
   input  wire pia_port_t port_sel,
   input  wire logic [7:0] wdata,
   input  wire logic      rnw,
   input  wire logic [7:0] kbd_pb,
   input  wire logic      rept_n,
   input  wire logic      cas_in,
   input  wire logic      fs_n,
   output logic [7:0]     pia_rdata,
   output logic [3:0]     kbd_row,
   output logic           an_g,
   output logic [2:0]     gm,
   output logic           css,
   output logic           cas_out,
   output logic           sound
);

   // Port A output latch, port C low nibble latch
   logic [7:0] pa_r;
   logic [3:0] pc_r;
   // Cassette tone divider and square wave
   logic [$clog2(cas_div_len)-1:0] cas_div;
   logic cas_tone;

   // ==================================================
   // Port registers
   // ==================================================

   // Fixed directions: A out, B in, C low out and C high in
   always_ff @(posedge clk25 or posedge reset)
   begin
      if (reset)
      begin
         pa_r <= 8'h00;
         pc_r <= 4'h0;
      end
      else if (sys_reset)
      begin
         pa_r <= 8'h00;
         pc_r <= 4'h0;
      end
      else if (cpu_clken && pia_sel && !rnw)
      begin
         case (port_sel)
            pia_port_a: pa_r <= wdata;
            pia_port_c: pc_r <= wdata[3:0];
            // Bit set/reset form only, mode words ignored
            pia_port_ctrl:
               if (!wdata[7])
                  pc_r[wdata[2:1]] <= wdata[0];
            default: ;
         endcase
      end
   end

   // Read back
   always_comb
   begin
      case (port_sel)
         pia_port_a: pia_rdata = pa_r;
         pia_port_b: pia_rdata = kbd_pb;
         pia_port_c: pia_rdata = {fs_n, rept_n, cas_in, cas_tone, pc_r};
         default:    pia_rdata = 8'h00;
      endcase
   end

   // ==================================================
   // Cassette tone
   // ==================================================

   // Roughly 2.4 kHz at 1 MHz
   always_ff @(posedge clk25 or posedge reset)
   begin
      if (reset)
      begin
         cas_div  <= '0;
         cas_tone <= 1'b0;
      end
      else if (cpu_clken)
      begin
         if (cas_div == cas_div_len - 1)
         begin
            cas_div  <= '0;
            cas_tone <= !cas_tone;
         end
         else
            cas_div <= cas_div + 1'b1;
      end
   end

   // Keyboard row select and display mode
   assign kbd_row = pa_r[3:0];
   assign an_g    = pa_r[4];
   assign gm      = pa_r[7:5];

   // PC0 enables output, PC1 high gates in the tone
   assign cas_out = pc_r[0] && (!cas_tone || !pc_r[1]);
   assign sound   = pc_r[2];
   assign css     = pc_r[3];

endmodule

`default_nettype wire

//--- atom_bus_decode.sv
`timescale 1ns/10ps
`default_nettype none

module atom_bus_decode import atom_map_pkg::*;
(
   input  wire logic              clk25,
   input  wire logic              reset,
   input  wire logic              sys_reset,
   input  wire logic              cpu_clken,
   input  wire logic [addr_w-1:0] address,
   input  wire logic [7:0]        wdata,
   input  wire logic              rnw,
   input  wire logic [7:0]        pia_rdata,
   input  wire logic [7:0]        vid_rdata,
   input  wire logic [7:0]        ext_rdata,
   output bus_region_t            region,
   output logic [ram_addr_w-1:0]  ram_addr,
   output logic                   ram_we,
   output logic [7:0]             rdata,
   output logic                   lock
);

   // Paged ROM latch at BFFF, low 3 bits pick the A000 page
   logic [7:0] rom_latch;
   // A000-AFFF window into the paged ROM
   logic paged_rom;
   // Write strobe for this bus cycle
   logic wr_stb;

   // ==================================================
   // Region decode
   // ==================================================

   // Exact matches first, then the wide ranges
   always_comb
   begin
      if (address == 16'hbfff)
         region = region_rom_latch;
      else if (address[15:4] == 12'hb00)
         region = region_pia;
      else if (address[15:4] == 12'hb40)
         region = region_blank;
      else if (address[15:12] == 4'h8 || address[15:11] == 5'b10010)
         region = region_vid;
      else if (address[15:12] == 4'ha || address[15:14] == 2'b11)
         region = region_rom;
      else
         region = region_ram;
   end

   assign paged_rom = (address[15:12] == 4'ha);
   assign wr_stb    = cpu_clken && !rnw;

   // ==================================================
   // ROM latch and lock snoop
   // ==================================================

   always_ff @(posedge clk25 or posedge reset)
   begin
      if (reset)
         rom_latch <= 8'h00;
      else if (sys_reset)
         rom_latch <= 8'h00;
      else if (wr_stb && region == region_rom_latch)
         rom_latch <= wdata;
   end

   // OS keeps its lock flag in zero page, mirrored out as a level
   always_ff @(posedge clk25 or posedge reset)
   begin
      if (reset)
         lock <= 1'b0;
      else if (sys_reset)
         lock <= 1'b0;
      else if (wr_stb && address == lock_addr)
         lock <= wdata[lock_bit];
   end

   // ==================================================
   // External SRAM
   // ==================================================

   // Paged window maps to 32 KB of ROM images above 64 KB
   assign ram_addr = paged_rom ?
                     {rom_page_prefix, rom_latch[2:0], address[11:0]} :
                     {2'b00, address};

   // ROM space is write protected
   assign ram_we = wr_stb && (region != region_rom);

   // ==================================================
   // Read data multiplexer
   // ==================================================

   always_comb
   begin
      case (region)
         region_vid:       rdata = vid_rdata;
         region_pia:       rdata = pia_rdata;
         region_blank:     rdata = 8'h00;
         region_rom_latch: rdata = rom_latch;
         default:          rdata = ext_rdata;
      endcase
   end

endmodule

`default_nettype wire

//--- atom_clock_reset.sv
`timescale 1ns/10ps
`default_nettype none

module atom_clock_reset import atom_timing_pkg::*;
(
   input  wire logic   clk25,
   input  wire logic   reset,
   input  wire turbo_t turbo,
   output logic        cpu_clken,
   output logic        sys_reset
);

   // Frame position, 0 to div_frame-1
   logic [$clog2(div_frame)-1:0] clk_div;
   // Enable slot for the current speed
   logic clken_next;
   // Power-up count of CPU enables
   logic [pwr_up_w-1:0] pwr_up_cnt;
   logic pwr_up_full;

   // ==================================================
   // Clock-enable divider
   // ==================================================

   always_ff @(posedge clk25 or posedge reset)
   begin
      if (reset)
         clk_div <= '0;
      else if (clk_div == div_frame - 1)
         clk_div <= '0;
      else
         clk_div <= clk_div + 1'b1;
   end

   // Pulses evenly spaced over the first 16 clocks
   // Remaining 9 clocks of the frame stay idle
   always_comb
   begin
      clken_next = 1'b0;
      if (clk_div < 16)
      begin
         case (turbo)
            turbo_1mhz: clken_next = (clk_div[3:0] == 4'd0);
            turbo_2mhz: clken_next = (clk_div[2:0] == 3'd0);
            turbo_4mhz: clken_next = (clk_div[1:0] == 2'd0);
            turbo_8mhz: clken_next = (clk_div[0] == 1'b0);
            default:    clken_next = 1'b0;
         endcase
      end
   end

   // Registered so the strobe is glitch free
   always_ff @(posedge clk25 or posedge reset)
   begin
      if (reset)
         cpu_clken <= 1'b0;
      else
         cpu_clken <= clken_next;
   end

   // ==================================================
   // Power-up reset
   // ==================================================

   assign pwr_up_full = &pwr_up_cnt;

   // Counter saturates, sys_reset drops on the enable after full
   always_ff @(posedge clk25 or posedge reset)
   begin
      if (reset)
      begin
         pwr_up_cnt <= '0;
         sys_reset  <= 1'b1;
      end
      else if (cpu_clken)
      begin
         if (!pwr_up_full)
            pwr_up_cnt <= pwr_up_cnt + 1'b1;
         sys_reset <= !pwr_up_full;
      end
   end

endmodule

`default_nettype wire

//--- atom_timing_pkg.sv
`default_nettype none

package atom_timing_pkg;

   // ==================================================
   // Clock enables
   // ==================================================

   // 25 MHz clocks per 1 us frame
   localparam int div_frame = 25;

   // Turbo speed, CPU enables per frame 1/2/4/8
   typedef enum logic [1:0] {
      turbo_1mhz,
      turbo_2mhz,
      turbo_4mhz,
      turbo_8mhz
   } turbo_t;

   // ==================================================
   // Power-up reset
   // ==================================================

   // Counter runs on CPU enables, about 1 ms at 1 MHz
   localparam int pwr_up_w = 10;

   // ==================================================
   // Cassette
   // ==================================================

   // Enables per tone half-period
   // 16 x 13, close to the original 4 MHz chain
   localparam int cas_div_len = 208;

endpackage

`default_nettype wire

//--- atom_map_pkg.sv
`default_nettype none

package atom_map_pkg;

   // ==================================================
   // Bus and memory widths
   // ==================================================

   // CPU bus address
   localparam int addr_w = 16;
   // External SRAM, 256 KB
   localparam int ram_addr_w = 18;
   // Video RAM, 8 KB
   localparam int vid_addr_w = 13;

   // ==================================================
   // Memory map
   // ==================================================

   // Bus regions, in decode priority order
   typedef enum logic [2:0] {
      region_ram,        // Everything not listed below
      region_vid,        // 8000-97FF
      region_rom,        // A000-AFFF and C000-FFFF
      region_pia,        // B000-B00F
      region_blank,      // B400-B40F, reads zero
      region_rom_latch   // BFFF
   } bus_region_t;

   // 8255 register select, address bits 1..0
   typedef enum logic [1:0] {
      pia_port_a,
      pia_port_b,
      pia_port_c,
      pia_port_ctrl
   } pia_port_t;

   // Lock flag lives in bit 5 of zero page E7
   localparam logic [addr_w-1:0] lock_addr = 16'h00e7;
   localparam int lock_bit = 5;

   // Top bits of a paged ROM address in SRAM
   localparam logic [2:0] rom_page_prefix = 3'b010;

endpackage

`default_nettype wire
